// ==== cache_pkg.sv ====
`default_nettype none

package cache_pkg;

	////////////////////
	// geometry
	////////////////////

	// 32-bit byte address
	localparam int ADDR_WIDTH = 32;
	// 64 sets of 8 ways
	localparam int SETS = 64;
	localparam int WAYS = 8;
	// 64-byte lines
	localparam int OFFSET_WIDTH = 6;
	localparam int INDEX_WIDTH = 6;
	// tag is addr 31:12
	localparam int TAG_WIDTH = ADDR_WIDTH - INDEX_WIDTH - OFFSET_WIDTH;
	// one counter per way, 0 is least recent
	localparam int LRU_WIDTH = 3;
	localparam int LRU_MRU = 7;

	////////////////////
	// encodings
	////////////////////

	// trace command codes, 5 and 7 are not used
	typedef enum logic [2:0] {
		CMD_READ_DATA = 3'd0,
		CMD_WRITE = 3'd1,
		CMD_READ_INSTR = 3'd2,
		CMD_SNOOP_INV = 3'd3,
		CMD_SNOOP_READ = 3'd4,
		CMD_SNOOP_RWITM = 3'd6
	} cmd_t;

	// line state
	typedef enum logic [1:0] {
		MESI_M = 2'd0,
		MESI_E = 2'd1,
		MESI_S = 2'd2,
		MESI_I = 2'd3
	} mesi_t;

	// bus snoop result, own and other caches
	typedef enum logic [1:0] {
		SNOOP_HIT = 2'd0,
		SNOOP_HITM = 2'd1,
		SNOOP_MISS = 2'd2
	} snoop_t;

	typedef logic [TAG_WIDTH-1:0] tag_t;
	typedef logic [INDEX_WIDTH-1:0] index_t;
	typedef logic [$clog2(WAYS)-1:0] way_t;
	typedef logic [LRU_WIDTH-1:0] lru_t;
	typedef logic [31:0] count_t;

endpackage

`default_nettype wire

// ==== req_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module req_decode import cache_pkg::*;
(
	input wire logic clk,
	input wire logic rst,
	input wire logic req_valid,
	input wire cmd_t req_cmd,
	input wire logic [ADDR_WIDTH-1:0] req_addr,
	output logic s1_valid,
	output logic s1_is_snoop,
	output logic s1_is_write,
	output logic s1_is_read,
	output cmd_t s1_cmd,
	output tag_t s1_tag,
	output index_t s1_index,
	output snoop_t s1_bus_snoop
);

	logic req_kept;
	logic in_valid;
	cmd_t in_cmd;
	logic [ADDR_WIDTH-1:0] in_addr;

	// only the six known codes get through
	always_comb
	begin
		case (req_cmd)
			CMD_READ_DATA, CMD_WRITE, CMD_READ_INSTR,
			CMD_SNOOP_INV, CMD_SNOOP_READ, CMD_SNOOP_RWITM:
				req_kept = 1'b1;
			default:
				req_kept = 1'b0;
		endcase
	end

	////////////////////
	// input capture
	////////////////////

	always_ff @(posedge clk)
	begin
		if (rst)
			in_valid <= 1'b0;
		else
			in_valid <= req_valid & req_kept;
	end

	always_ff @(posedge clk)
	begin
		in_cmd <= req_cmd;
		in_addr <= req_addr;
	end

	////////////////////
	// classify and split
	////////////////////

	always_ff @(posedge clk)
	begin
		if (rst)
			s1_valid <= 1'b0;
		else
			s1_valid <= in_valid;
	end

	always_ff @(posedge clk)
	begin
		s1_cmd <= in_cmd;
		s1_is_write <= (in_cmd == CMD_WRITE);
		s1_is_read <= (in_cmd == CMD_READ_DATA) || (in_cmd == CMD_READ_INSTR);
		s1_is_snoop <= (in_cmd == CMD_SNOOP_INV) || (in_cmd == CMD_SNOOP_READ)
			|| (in_cmd == CMD_SNOOP_RWITM);
		s1_tag <= in_addr[ADDR_WIDTH-1 -: TAG_WIDTH];
		s1_index <= in_addr[OFFSET_WIDTH +: INDEX_WIDTH];
		// other caches answer through addr 1:0
		case (in_addr[1:0])
			2'b00: s1_bus_snoop <= SNOOP_HIT;
			2'b10: s1_bus_snoop <= SNOOP_HITM;
			default: s1_bus_snoop <= SNOOP_MISS;
		endcase
	end

endmodule

`default_nettype wire

// ==== lru_order.sv ====
`timescale 1ns/1ps
`default_nettype none

module lru_order import cache_pkg::*;
(
	input wire lru_t [WAYS-1:0] lru_set,
	input wire logic [WAYS-1:0] valid_set,
	input wire logic hit,
	input wire way_t hit_way,
	output way_t victim_way,
	output way_t access_way,
	output lru_t [WAYS-1:0] next_lru_set
);

	logic inv_found;
	way_t inv_way;
	way_t old_way;
	lru_t access_lru;

	////////////////////
	// victim choice
	////////////////////

	// lowest invalid way first
	always_comb
	begin
		inv_found = 1'b0;
		inv_way = '0;
		for (int w = 0; w < WAYS; w++)
		begin
			if (!valid_set[w] && !inv_found)
			begin
				inv_found = 1'b1;
				inv_way = way_t'(w);
			end
		end
	end

	// in a full set counter 0 is the oldest
	always_comb
	begin
		old_way = '0;
		for (int w = WAYS - 1; w >= 0; w--)
			if (lru_set[w] == '0)
				old_way = way_t'(w);
	end

	assign victim_way = inv_found ? inv_way : old_way;
	assign access_way = hit ? hit_way : victim_way;

	////////////////////
	// counter update
	////////////////////

	// same rule on hit and fill
	assign access_lru = lru_set[access_way];

	always_comb
	begin
		for (int w = 0; w < WAYS; w++)
		begin
			if (way_t'(w) == access_way)
				next_lru_set[w] = lru_t'(LRU_MRU);
			else if (lru_set[w] > access_lru)
				next_lru_set[w] = lru_set[w] - lru_t'(1);
			else
				next_lru_set[w] = lru_set[w];
		end
	end

endmodule

`default_nettype wire

// ==== mesi_next.sv ====
`timescale 1ns/1ps
`default_nettype none

module mesi_next import cache_pkg::*;
(
	input wire cmd_t cmd,
	input wire logic hit,
	input wire mesi_t cur_state,
	input wire snoop_t bus_snoop,
	output mesi_t next_state,
	output snoop_t snoop_resp,
	output logic fetch,
	output logic wb
);

	logic shared;

	// another cache holds the line
	assign shared = (bus_snoop == SNOOP_HIT) || (bus_snoop == SNOOP_HITM);

	// answer for snooped commands
	always_comb
	begin
		if (!hit)
			snoop_resp = SNOOP_MISS;
		else if (cur_state == MESI_M)
			snoop_resp = SNOOP_HITM;
		else
			snoop_resp = SNOOP_HIT;
	end

	////////////////////
	// state moves
	////////////////////

	always_comb
	begin
		next_state = cur_state;
		fetch = 1'b0;
		wb = 1'b0;
		case (cmd)
			CMD_READ_DATA, CMD_READ_INSTR:
			begin
				fetch = !hit;
				// dirty line keeps M on a read
				if (!(hit && cur_state == MESI_M))
					next_state = shared ? MESI_S : MESI_E;
			end
			CMD_WRITE:
			begin
				fetch = !hit;
				next_state = MESI_M;
			end
			CMD_SNOOP_READ:
			begin
				if (hit)
				begin
					wb = (cur_state == MESI_M);
					next_state = MESI_S;
				end
			end
			CMD_SNOOP_RWITM:
			begin
				if (hit)
				begin
					wb = (cur_state == MESI_M);
					next_state = MESI_I;
				end
			end
			CMD_SNOOP_INV:
			begin
				// only shared copies drop
				if (hit && cur_state == MESI_S)
					next_state = MESI_I;
			end
			default:
				next_state = cur_state;
		endcase
	end

endmodule

`default_nettype wire

// ==== tag_directory.sv ====
`timescale 1ns/1ps
`default_nettype none

module tag_directory import cache_pkg::*;
(
	input wire logic clk,
	input wire logic rst,
	input wire logic s1_valid,
	input wire logic s1_is_snoop,
	input wire logic s1_is_write,
	input wire logic s1_is_read,
	input wire cmd_t s1_cmd,
	input wire tag_t s1_tag,
	input wire index_t s1_index,
	input wire snoop_t s1_bus_snoop,
	output logic resp_valid,
	output logic resp_hit,
	output way_t resp_way,
	output mesi_t resp_state,
	output logic resp_write,
	output logic snoop_valid,
	output snoop_t snoop_resp,
	output logic mem_fetch,
	output logic writeback
);

	// directory arrays
	tag_t tag_mem [SETS][WAYS];
	mesi_t state_mem [SETS][WAYS];
	lru_t lru_mem [SETS][WAYS];

	logic l1_req;
	logic snoop_req;
	logic hit;
	way_t hit_way;
	logic [WAYS-1:0] valid_set;
	lru_t [WAYS-1:0] lru_set;
	lru_t [WAYS-1:0] next_lru_set;
	way_t victim_way;
	way_t access_way;
	mesi_t cur_state;
	mesi_t next_state;
	snoop_t snoop_next;
	logic fetch;
	logic wb;

	assign l1_req = s1_valid & (s1_is_read | s1_is_write);
	assign snoop_req = s1_valid & s1_is_snoop;

	////////////////////
	// set lookup
	////////////////////

	// all ways compared at once and the lowest matching way wins
	always_comb
	begin
		hit = 1'b0;
		hit_way = '0;
		for (int w = WAYS - 1; w >= 0; w--)
		begin
			valid_set[w] = (state_mem[s1_index][w] != MESI_I);
			lru_set[w] = lru_mem[s1_index][w];
			if (valid_set[w] && (tag_mem[s1_index][w] == s1_tag))
			begin
				hit = 1'b1;
				hit_way = way_t'(w);
			end
		end
	end

	// a miss enters as an invalid line
	assign cur_state = hit ? state_mem[s1_index][hit_way] : MESI_I;

	lru_order u_lru_order (
		.lru_set(lru_set),
		.valid_set(valid_set),
		.hit(hit),
		.hit_way(hit_way),
		.victim_way(victim_way),
		.access_way(access_way),
		.next_lru_set(next_lru_set)
	);

	mesi_next u_mesi_next (
		.cmd(s1_cmd),
		.hit(hit),
		.cur_state(cur_state),
		.bus_snoop(s1_bus_snoop),
		.next_state(next_state),
		.snoop_resp(snoop_next),
		.fetch(fetch),
		.wb(wb)
	);

	////////////////////
	// array update
	////////////////////

	// written in the lookup cycle so a following command sees it
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			for (int s = 0; s < SETS; s++)
			begin
				for (int w = 0; w < WAYS; w++)
				begin
					tag_mem[s][w] <= '0;
					state_mem[s][w] <= MESI_I;
					lru_mem[s][w] <= lru_t'(w);
				end
			end
		end
		else if (l1_req)
		begin
			// fill takes the new tag while a hit keeps its own
			if (!hit)
				tag_mem[s1_index][victim_way] <= s1_tag;
			state_mem[s1_index][access_way] <= next_state;
			for (int w = 0; w < WAYS; w++)
				lru_mem[s1_index][w] <= next_lru_set[w];
		end
		else if (snoop_req && hit)
			// snoops touch state only
			state_mem[s1_index][hit_way] <= next_state;
	end

	////////////////////
	// response
	////////////////////

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			resp_valid <= 1'b0;
			snoop_valid <= 1'b0;
			mem_fetch <= 1'b0;
			writeback <= 1'b0;
		end
		else
		begin
			resp_valid <= l1_req;
			snoop_valid <= snoop_req;
			mem_fetch <= l1_req & fetch;
			writeback <= snoop_req & wb;
		end
	end

	always_ff @(posedge clk)
	begin
		resp_hit <= hit;
		resp_way <= access_way;
		resp_state <= next_state;
		resp_write <= s1_is_write;
		snoop_resp <= snoop_next;
	end

endmodule

`default_nettype wire

// ==== cache_stats.sv ====
`timescale 1ns/1ps
`default_nettype none

module cache_stats import cache_pkg::*;
(
	input wire logic clk,
	input wire logic rst,
	input wire logic resp_valid,
	input wire logic resp_hit,
	input wire logic req_was_write,
	output count_t read_count,
	output count_t write_count,
	output count_t hit_count,
	output count_t miss_count
);

	////////////////////
	// L1 request counters
	////////////////////

	// snoops never raise resp_valid
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			read_count <= '0;
			write_count <= '0;
			hit_count <= '0;
			miss_count <= '0;
		end
		else if (resp_valid)
		begin
			// kind of request
			if (req_was_write)
				write_count <= write_count + count_t'(1);
			else
				read_count <= read_count + count_t'(1);
			// lookup outcome
			if (resp_hit)
				hit_count <= hit_count + count_t'(1);
			else
				miss_count <= miss_count + count_t'(1);
		end
	end

endmodule

`default_nettype wire

// ==== l2_cache_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module l2_cache_top import cache_pkg::*;
(
	input wire logic clk,
	input wire logic rst,
	input wire logic req_valid,
	input wire cmd_t req_cmd,
	input wire logic [ADDR_WIDTH-1:0] req_addr,
	output logic resp_valid,
	output logic resp_hit,
	output way_t resp_way,
	output mesi_t resp_state,
	output logic snoop_valid,
	output snoop_t snoop_resp,
	output logic mem_fetch,
	output logic writeback,
	output count_t read_count,
	output count_t write_count,
	output count_t hit_count,
	output count_t miss_count
);

	// stage 1 to stage 2
	logic s1_valid;
	logic s1_is_snoop;
	logic s1_is_write;
	logic s1_is_read;
	cmd_t s1_cmd;
	tag_t s1_tag;
	index_t s1_index;
	snoop_t s1_bus_snoop;
	// write flag for the counters
	logic resp_write;

	req_decode u_req_decode (
		.clk(clk),
		.rst(rst),
		.req_valid(req_valid),
		.req_cmd(req_cmd),
		.req_addr(req_addr),
		.s1_valid(s1_valid),
		.s1_is_snoop(s1_is_snoop),
		.s1_is_write(s1_is_write),
		.s1_is_read(s1_is_read),
		.s1_cmd(s1_cmd),
		.s1_tag(s1_tag),
		.s1_index(s1_index),
		.s1_bus_snoop(s1_bus_snoop)
	);

	tag_directory u_tag_directory (
		.clk(clk),
		.rst(rst),
		.s1_valid(s1_valid),
		.s1_is_snoop(s1_is_snoop),
		.s1_is_write(s1_is_write),
		.s1_is_read(s1_is_read),
		.s1_cmd(s1_cmd),
		.s1_tag(s1_tag),
		.s1_index(s1_index),
		.s1_bus_snoop(s1_bus_snoop),
		.resp_valid(resp_valid),
		.resp_hit(resp_hit),
		.resp_way(resp_way),
		.resp_state(resp_state),
		.resp_write(resp_write),
		.snoop_valid(snoop_valid),
		.snoop_resp(snoop_resp),
		.mem_fetch(mem_fetch),
		.writeback(writeback)
	);

	cache_stats u_cache_stats (
		.clk(clk),
		.rst(rst),
		.resp_valid(resp_valid),
		.resp_hit(resp_hit),
		.req_was_write(resp_write),
		.read_count(read_count),
		.write_count(write_count),
		.hit_count(hit_count),
		.miss_count(miss_count)
	);

endmodule

`default_nettype wire

// ==== l2_cache_assert.sv ====
`timescale 1ns/1ps
`default_nettype none

module l2_cache_assert import cache_pkg::*;
(
	input wire logic clk,
	input wire logic rst,
	input wire logic req_valid,
	input wire cmd_t req_cmd,
	input wire logic resp_valid,
	input wire logic resp_hit,
	input wire logic snoop_valid,
	input wire snoop_t snoop_resp,
	input wire logic mem_fetch,
	input wire logic writeback
);

	////////////////////
	// strobe rules
	////////////////////

	// one response kind per cycle
	a_one_strobe: assert property (@(posedge clk) disable iff (rst)
		!(resp_valid && snoop_valid))
		else $error("resp_valid and snoop_valid high in the same cycle");

	// fetch only on an L1 miss
	a_fetch_on_miss: assert property (@(posedge clk) disable iff (rst)
		mem_fetch |-> (resp_valid && !resp_hit))
		else $error("mem_fetch without an L1 miss response");

	// writeback only for a snoop that found M
	a_wb_on_hitm: assert property (@(posedge clk) disable iff (rst)
		writeback |-> (snoop_valid && (snoop_resp == SNOOP_HITM)))
		else $error("writeback without a HITM snoop response");

	////////////////////
	// latency
	////////////////////

	// strobe is set two edges after the sampling edge and seen three ticks on
	a_resp_source: assert property (@(posedge clk) disable iff (rst)
		resp_valid |-> ($past(req_valid, 3) && ($past(req_cmd, 3) inside
		{CMD_READ_DATA, CMD_WRITE, CMD_READ_INSTR})))
		else $error("resp_valid without an L1 request two cycles before");

	a_snoop_source: assert property (@(posedge clk) disable iff (rst)
		snoop_valid |-> ($past(req_valid, 3) && ($past(req_cmd, 3) inside
		{CMD_SNOOP_INV, CMD_SNOOP_READ, CMD_SNOOP_RWITM})))
		else $error("snoop_valid without a snooped command two cycles before");

endmodule

bind l2_cache_top l2_cache_assert u_l2_cache_assert (
	.clk(clk),
	.rst(rst),
	.req_valid(req_valid),
	.req_cmd(req_cmd),
	.resp_valid(resp_valid),
	.resp_hit(resp_hit),
	.snoop_valid(snoop_valid),
	.snoop_resp(snoop_resp),
	.mem_fetch(mem_fetch),
	.writeback(writeback)
);

`default_nettype wire

// ==== tb_l2_cache.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_l2_cache import cache_pkg::*;
();

	// directed count is an upper bound on the run length
	localparam int DIRECTED_CMDS = 40;
	localparam int RANDOM_SLOTS = 300;
	localparam int CYCLE_LIMIT = (DIRECTED_CMDS + RANDOM_SLOTS) * 2 + 50;

	// one predicted response
	typedef struct packed {
		logic is_snoop;
		logic hit;
		way_t way;
		mesi_t state;
		snoop_t snp;
		logic fetch;
		logic wb;
		int unsigned due;
	} expect_t;

	logic clk;
	logic rst;
	logic req_valid;
	cmd_t req_cmd;
	logic [ADDR_WIDTH-1:0] req_addr;
	logic resp_valid;
	logic resp_hit;
	way_t resp_way;
	mesi_t resp_state;
	logic snoop_valid;
	snoop_t snoop_resp;
	logic mem_fetch;
	logic writeback;
	count_t read_count;
	count_t write_count;
	count_t hit_count;
	count_t miss_count;

	// reference directory
	tag_t m_tag [SETS][WAYS];
	mesi_t m_state [SETS][WAYS];
	lru_t m_lru [SETS][WAYS];
	int m_reads;
	int m_writes;
	int m_hits;
	int m_misses;

	expect_t exp_q [$];
	logic [15:0] lfsr;
	int unsigned cycle_count = 0;
	int checks = 0;
	int errors = 0;

	l2_cache_top DUT (
		.clk(clk),
		.rst(rst),
		.req_valid(req_valid),
		.req_cmd(req_cmd),
		.req_addr(req_addr),
		.resp_valid(resp_valid),
		.resp_hit(resp_hit),
		.resp_way(resp_way),
		.resp_state(resp_state),
		.snoop_valid(snoop_valid),
		.snoop_resp(snoop_resp),
		.mem_fetch(mem_fetch),
		.writeback(writeback),
		.read_count(read_count),
		.write_count(write_count),
		.hit_count(hit_count),
		.miss_count(miss_count)
	);

	// 40 ns period
	always #20 clk = ~clk;

	////////////////////
	// random source
	////////////////////

	// x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic take_bits(input int n, output logic [31:0] val);
		val = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr = lfsr_step(lfsr);
			val = {val[30:0], lfsr[0]};
		end
	endtask

	function automatic logic [31:0] make_addr(input tag_t t, input index_t ix,
		input logic [1:0] lo);
		return {t, ix, 4'b0000, lo};
	endfunction

	////////////////////
	// reference model
	////////////////////

	task automatic init_model();
		for (int s = 0; s < SETS; s++)
		begin
			for (int w = 0; w < WAYS; w++)
			begin
				m_tag[s][w] = '0;
				m_state[s][w] = MESI_I;
				m_lru[s][w] = lru_t'(w);
			end
		end
		m_reads = 0;
		m_writes = 0;
		m_hits = 0;
		m_misses = 0;
	endtask

	// first empty way or else the oldest
	function automatic int pick_victim(input index_t ix);
		for (int w = 0; w < WAYS; w++)
			if (m_state[ix][w] == MESI_I)
				return w;
		for (int w = 0; w < WAYS; w++)
			if (m_lru[ix][w] == '0)
				return w;
		return 0;
	endfunction

	// updates the model and returns what the DUT should answer
	function automatic expect_t predict(input logic [2:0] cmd, input logic [31:0] addr);
		expect_t e;
		tag_t t;
		index_t ix;
		snoop_t bus;
		int hw;
		int aw;
		mesi_t cur;
		mesi_t nxt;
		lru_t old;
		t = addr[31:12];
		ix = addr[11:6];
		bus = (addr[1:0] == 2'b00) ? SNOOP_HIT
			: (addr[1:0] == 2'b10) ? SNOOP_HITM : SNOOP_MISS;
		hw = -1;
		for (int w = 0; w < WAYS; w++)
			if (hw < 0 && m_state[ix][w] != MESI_I && m_tag[ix][w] == t)
				hw = w;
		cur = (hw >= 0) ? m_state[ix][hw] : MESI_I;
		e = '0;
		e.hit = (hw >= 0);
		e.is_snoop = (cmd == 3'd3) || (cmd == 3'd4) || (cmd == 3'd6);
		if (!e.is_snoop)
		begin
			aw = e.hit ? hw : pick_victim(ix);
			if (cmd == 3'd1)
				nxt = MESI_M;
			else if (cur == MESI_M)
				nxt = MESI_M;
			else if (bus == SNOOP_MISS)
				nxt = MESI_E;
			else
				nxt = MESI_S;
			// accessed way goes to MRU and younger ones age by one
			old = m_lru[ix][aw];
			for (int w = 0; w < WAYS; w++)
			begin
				if (w == aw)
					m_lru[ix][w] = lru_t'(LRU_MRU);
				else if (m_lru[ix][w] > old)
					m_lru[ix][w] = m_lru[ix][w] - lru_t'(1);
			end
			m_tag[ix][aw] = t;
			m_state[ix][aw] = nxt;
			if (cmd == 3'd1)
				m_writes++;
			else
				m_reads++;
			if (e.hit)
				m_hits++;
			else
				m_misses++;
			e.way = way_t'(aw);
			e.state = nxt;
			e.fetch = !e.hit;
		end
		else
		begin
			e.snp = !e.hit ? SNOOP_MISS : (cur == MESI_M) ? SNOOP_HITM : SNOOP_HIT;
			if (e.hit)
			begin
				if (cmd == 3'd4)
					nxt = MESI_S;
				else if (cmd == 3'd6)
					nxt = MESI_I;
				else
					nxt = (cur == MESI_S) ? MESI_I : cur;
				e.wb = (cmd != 3'd3) && (cur == MESI_M);
				m_state[ix][hw] = nxt;
			end
		end
		return e;
	endfunction

	////////////////////
	// compare tasks
	////////////////////

	task automatic flag_check(input string name, input logic got, input bit exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("CHECK FAILED %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic state_check(input string name, input mesi_t got, input mesi_t exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("CHECK FAILED %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic snoop_check(input string name, input snoop_t got, input snoop_t exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("CHECK FAILED %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic way_check(input string name, input way_t got, input way_t exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("CHECK FAILED %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic count_check(input string name, input count_t got, input count_t exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("CHECK FAILED %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic compare_entry(input expect_t e);
		if (e.is_snoop)
		begin
			flag_check("snoop_valid", snoop_valid, 1'b1);
			flag_check("resp_valid", resp_valid, 1'b0);
			snoop_check("snoop_resp", snoop_resp, e.snp);
			flag_check("writeback", writeback, e.wb);
			flag_check("mem_fetch", mem_fetch, 1'b0);
		end
		else
		begin
			flag_check("resp_valid", resp_valid, 1'b1);
			flag_check("snoop_valid", snoop_valid, 1'b0);
			flag_check("resp_hit", resp_hit, e.hit);
			way_check("resp_way", resp_way, e.way);
			state_check("resp_state", resp_state, e.state);
			flag_check("mem_fetch", mem_fetch, e.fetch);
			flag_check("writeback", writeback, 1'b0);
		end
	endtask

	// outputs settle after the rising edge and are looked at on the falling one
	always @(negedge clk)
	begin : compare_proc
		expect_t e;
		logic strobe;
		strobe = (resp_valid === 1'b1) || (snoop_valid === 1'b1);
		if (exp_q.size() > 0 && exp_q[0].due == cycle_count)
		begin
			e = exp_q.pop_front();
			if (!strobe)
			begin
				errors++;
				$display("no response strobe for the command due in cycle %0d", e.due);
			end
			else
				compare_entry(e);
		end
		else if (strobe)
		begin
			errors++;
			$display("response strobe in cycle %0d with no command queued for it",
				cycle_count);
		end
	end

	////////////////////
	// watchdog
	////////////////////

	always @(posedge clk)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= CYCLE_LIMIT)
		begin
			$display("timeout at cycle %0d with %0d responses pending",
				cycle_count, exp_q.size());
			$display("checks %0d, errors %0d", checks, errors + 1);
			$display("TB FAILED");
			$finish;
		end
	end

	////////////////////
	// stimulus
	////////////////////

	// codes 5 and 7 get no prediction
	task automatic issue_cmd(input logic [2:0] cmd, input logic [31:0] addr);
		expect_t e;
		req_valid = 1'b1;
		req_cmd = cmd_t'(cmd);
		req_addr = addr;
		if (cmd != 3'd5 && cmd != 3'd7)
		begin
			e = predict(cmd, addr);
			e.due = cycle_count + 3;
			exp_q.push_back(e);
		end
		@(negedge clk);
		req_valid = 1'b0;
	endtask

	task automatic idle_cycle();
		req_valid = 1'b0;
		@(negedge clk);
	endtask

	task automatic directed_tests();
		// eight fills into set 0 give E or S by addr 1:0
		for (int i = 0; i < WAYS; i++)
			issue_cmd(3'd0, make_addr(tag_t'(i + 1), index_t'(0), 2'(i)));
		// hits then a write to M that a later read keeps
		issue_cmd(3'd2, make_addr(tag_t'(3), index_t'(0), 2'b01));
		issue_cmd(3'd1, make_addr(tag_t'(3), index_t'(0), 2'b00));
		issue_cmd(3'd0, make_addr(tag_t'(3), index_t'(0), 2'b00));
		issue_cmd(3'd1, make_addr(tag_t'(5), index_t'(0), 2'b11));
		// ninth and later tags evict
		issue_cmd(3'd0, make_addr(tag_t'(9), index_t'(0), 2'b01));
		issue_cmd(3'd2, make_addr(tag_t'(10), index_t'(0), 2'b00));
		issue_cmd(3'd1, make_addr(tag_t'(11), index_t'(0), 2'b10));
		// snoops on M, E/S and absent lines
		issue_cmd(3'd4, make_addr(tag_t'(3), index_t'(0), 2'b00));
		issue_cmd(3'd4, make_addr(tag_t'(4), index_t'(0), 2'b00));
		issue_cmd(3'd6, make_addr(tag_t'(5), index_t'(0), 2'b00));
		issue_cmd(3'd6, make_addr(tag_t'(6), index_t'(0), 2'b00));
		issue_cmd(3'd6, make_addr(tag_t'(11), index_t'(0), 2'b00));
		issue_cmd(3'd4, make_addr(tag_t'(12), index_t'(0), 2'b00));
		// invalidate drops S and leaves E
		issue_cmd(3'd0, make_addr(tag_t'(20), index_t'(1), 2'b00));
		issue_cmd(3'd3, make_addr(tag_t'(20), index_t'(1), 2'b00));
		issue_cmd(3'd0, make_addr(tag_t'(20), index_t'(1), 2'b01));
		issue_cmd(3'd3, make_addr(tag_t'(20), index_t'(1), 2'b00));
		issue_cmd(3'd0, make_addr(tag_t'(20), index_t'(1), 2'b11));
		issue_cmd(3'd4, make_addr(tag_t'(20), index_t'(1), 2'b00));
		// unknown codes get no strobe
		issue_cmd(3'd5, make_addr(tag_t'(3), index_t'(0), 2'b00));
		issue_cmd(3'd7, make_addr(tag_t'(20), index_t'(1), 2'b00));
		idle_cycle();
	endtask

	// 12 tags over 2 sets
	task automatic random_tests();
		logic [31:0] r;
		logic [31:0] c;
		logic [31:0] tv;
		logic [31:0] ix;
		logic [31:0] lo;
		for (int i = 0; i < RANDOM_SLOTS; i++)
		begin
			take_bits(2, r);
			if (r[1:0] == 2'b00)
				idle_cycle();
			else
			begin
				take_bits(3, c);
				take_bits(4, tv);
				take_bits(1, ix);
				take_bits(2, lo);
				issue_cmd(c[2:0], make_addr(tag_t'(tv % 12 + 1), index_t'(ix), lo[1:0]));
			end
		end
	endtask

	initial
	begin
		clk = 1'b0;
		rst = 1'b1;
		req_valid = 1'b0;
		req_cmd = CMD_READ_DATA;
		req_addr = '0;
		lfsr = 16'd56955;
		init_model();
		repeat (5) @(negedge clk);
		rst = 1'b0;
		// state straight out of reset
		flag_check("resp_valid", resp_valid, 1'b0);
		flag_check("snoop_valid", snoop_valid, 1'b0);
		flag_check("mem_fetch", mem_fetch, 1'b0);
		flag_check("writeback", writeback, 1'b0);
		count_check("read_count", read_count, '0);
		count_check("write_count", write_count, '0);
		count_check("hit_count", hit_count, '0);
		count_check("miss_count", miss_count, '0);
		directed_tests();
		random_tests();
		while (exp_q.size() != 0)
			idle_cycle();
		// counters trail the last strobe by one edge
		repeat (2) idle_cycle();
		count_check("read_count", read_count, count_t'(m_reads));
		count_check("write_count", write_count, count_t'(m_writes));
		count_check("hit_count", hit_count, count_t'(m_hits));
		count_check("miss_count", miss_count, count_t'(m_misses));
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== verilog.f ====
cache_pkg.sv
req_decode.sv
lru_order.sv
mesi_next.sv
tag_directory.sv
cache_stats.sv
l2_cache_top.sv
l2_cache_assert.sv
tb_l2_cache.sv
